/* ppu_defines.svh */
/*
 * Picture processor constants: line and frame timing, CPU register offsets,
 * palette page and VRAM fetch address pieces
 */
`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

// Line and frame timing
`define LAST_CYCLE        9'd340   // Last cycle of a normal line
`define LAST_CYCLE_GROUP  6'd42    // Cycles 336..343
`define POST_RENDER_LINE  9'd240   // Idle line after the picture
`define VBLANK_END_LINE   9'd260   // Last vblank line
`define PRE_RENDER_LINE   9'd511   // Line -1 in 9 bits
`define VISIBLE_CYCLES    9'd256

// Scroll update points within a line
`define VERT_INC_CYCLE    9'd251
`define HORIZ_COPY_CYCLE  9'd256
`define VERT_COPY_CYCLE   9'd304   // Only on the pre-render line
`define PREFETCH_START    9'd320   // First two tiles of next line
`define PREFETCH_END      9'd336

// CPU register offsets
`define REG_CTRL    3'd0
`define REG_MASK    3'd1
`define REG_STATUS  3'd2
`define REG_SCROLL  3'd5
`define REG_ADDR    3'd6
`define REG_DATA    3'd7

`define PAL_PAGE    6'h3F    // Upper address bits of palette space
`define NT_BASE     2'b10    // Nametables live at 0x2000
`define ATTR_ROW    4'b1111  // Attribute block at the end of a nametable

`endif

/* ppu_pkg.sv */
/*
 * Shared types: scroll field view and the loopy
 * union over the VRAM address word
 */
package ppu_pkg;

  // Scroll fields, msb first
  typedef struct packed {
    logic [2:0] fine_y;    // Row within tile
    logic       nt_y;      // Vertical nametable select
    logic       nt_x;      // Horizontal nametable select
    logic [4:0] coarse_y;  // Tile row
    logic [4:0] coarse_x;  // Tile column
  } scroll_t;

  // Same 15 bits seen as a flat address or as scroll fields
  typedef union packed {
    logic [14:0] addr;
    scroll_t     f;
  } loopy_t;

endpackage

/* ppu_timing.sv */
/*
 * Scanline and cycle counters with odd-frame short pre-render line,
 * vblank flag and line event strobes
 */
`timescale 1ns/1ns
`include "ppu_defines.svh"

module ppu_timing (
  input  logic       clk,
  input  logic       reset,
  input  logic       rendering,        // Playfield on and inside picture
  output logic [8:0] scanline,
  output logic [8:0] cycle,
  output logic       in_vblank,
  output logic       end_of_line,      // Last cycle of the current line
  output logic       last_group,       // Cycles 336..343
  output logic       entering_vblank,
  output logic       exiting_vblank,
  output logic       pre_render        // On line -1
);

  logic odd_frame;   // Frame parity for the skipped cycle
  logic short_line;

  // Pre-render line drops its last cycle every second frame
  assign short_line = pre_render && odd_frame && rendering;

  assign last_group  = (cycle[8:3] == `LAST_CYCLE_GROUP);
  assign end_of_line = (cycle == (short_line ? `LAST_CYCLE - 9'd1 : `LAST_CYCLE));

  // Line events land on the wrap cycle
  assign entering_vblank = end_of_line && (scanline == `POST_RENDER_LINE);
  assign exiting_vblank  = end_of_line && (scanline == `VBLANK_END_LINE);

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle     <= 9'd0;
      in_vblank <= 1'b1;  // Start as if inside vblank
    end else begin
      cycle <= end_of_line ? 9'd0 : cycle + 9'd1;
      if (entering_vblank)
        in_vblank <= 1'b1;
      else if (exiting_vblank)
        in_vblank <= 1'b0;
    end
  end

  // Line counter and frame parity
  always_ff @(posedge clk) begin
    if (reset) begin
      scanline   <= 9'd0;
      pre_render <= 1'b0;
      odd_frame  <= 1'b0;
    end else if (end_of_line) begin
      // 260 jumps to -1, -1 rolls over to 0 by itself
      scanline   <= exiting_vblank ? `PRE_RENDER_LINE : scanline + 9'd1;
      pre_render <= exiting_vblank;
      if (exiting_vblank)
        odd_frame <= ~odd_frame;  // New frame begins
    end
  end

  // Counter must wrap before 341 on every line
  a_cycle_range: assert property (
    @(posedge clk) disable iff (reset) cycle <= `LAST_CYCLE
  );

endmodule

/* ppu_scroll.sv */
/*
 * Current and temporary scroll/address registers, fine X and write toggle,
 * CPU register decode, rendering increments and copies
 */
`timescale 1ns/1ns
`include "ppu_defines.svh"

module ppu_scroll import ppu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       rendering,
  input  logic       pre_render,
  input  logic [8:0] cycle,
  input  logic [2:0] ain,
  input  logic [7:0] din,
  input  logic       read,
  input  logic       write,
  output loopy_t     loopy,     // Current address, v
  output logic [2:0] fine_x
);

  loopy_t     v;       // Current VRAM address
  loopy_t     t;       // Temporary address
  logic [2:0] fx;
  logic       toggle;  // Second write of a pair
  logic       incr32;  // Data port step of 32
  logic       fetch_window;

  // Coarse X advances after each attribute fetch, picture and prefetch tiles
  assign fetch_window = (cycle < `VISIBLE_CYCLES) ||
                        (cycle >= `PREFETCH_START && cycle < `PREFETCH_END);

  always_ff @(posedge clk) begin
    if (reset) begin
      v.addr <= 15'd0;
      t.addr <= 15'd0;
      fx     <= 3'd0;
      toggle <= 1'b0;
      incr32 <= 1'b0;
    end else begin
      if (rendering) begin
        if (cycle[2:0] == 3'd3 && fetch_window) begin
          v.f.coarse_x <= v.f.coarse_x + 5'd1;
          if (v.f.coarse_x == 5'd31)
            v.f.nt_x <= ~v.f.nt_x;      // Cross into next nametable
        end
        if (cycle == `VERT_INC_CYCLE) begin
          v.f.fine_y <= v.f.fine_y + 3'd1;
          if (v.f.fine_y == 3'd7) begin
            if (v.f.coarse_y == 5'd29) begin  // Row 29 is the last tile row
              v.f.coarse_y <= 5'd0;
              v.f.nt_y     <= ~v.f.nt_y;
            end else begin
              v.f.coarse_y <= v.f.coarse_y + 5'd1;
            end
          end
        end
        if (cycle == `HORIZ_COPY_CYCLE) begin
          v.f.coarse_x <= t.f.coarse_x;
          v.f.nt_x     <= t.f.nt_x;
        end
        if (cycle == `VERT_COPY_CYCLE && pre_render)
          v <= t;                         // Full reload for a new frame
      end

      // CPU side, takes priority over the rendering updates
      if (write && ain == `REG_CTRL) begin
        t.f.nt_x <= din[0];
        t.f.nt_y <= din[1];
        incr32   <= din[2];
      end else if (write && ain == `REG_SCROLL) begin
        if (!toggle) begin
          t.f.coarse_x <= din[7:3];
          fx           <= din[2:0];
        end else begin
          t.f.coarse_y <= din[7:3];
          t.f.fine_y   <= din[2:0];
        end
        toggle <= ~toggle;
      end else if (write && ain == `REG_ADDR) begin
        if (!toggle) begin
          t.addr[14:8] <= {1'b0, din[5:0]};  // Top bit forced low
        end else begin
          t.addr[7:0] <= din;
          v.addr      <= {t.addr[14:8], din};
        end
        toggle <= ~toggle;
      end else if (read && ain == `REG_STATUS) begin
        toggle <= 1'b0;
      end else if ((read || write) && ain == `REG_DATA && !rendering) begin
        v.addr <= v.addr + (incr32 ? 15'd32 : 15'd1);
      end
    end
  end

  assign loopy  = v;
  assign fine_x = fx;

  // A status read always restarts the scroll/address write pair
  a_toggle_clear: assert property (
    @(posedge clk) disable iff (reset) (read && ain == `REG_STATUS) |=> !toggle
  );

endmodule

/* ppu_bg_painter.sv */
/*
 * Background fetch capture (name, attribute, pattern planes) and
 * pixel shift registers with fine X selection
 */
`timescale 1ns/1ns

module ppu_bg_painter import ppu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       enable,     // Shift pipes advance
  input  logic [2:0] cycle,      // Position in the 8-cycle fetch group
  input  logic [2:0] fine_x,
  input  loopy_t     loopy,
  input  logic [7:0] vram_din,
  output logic [7:0] name_byte,
  output logic [3:0] pixel
);

  logic [15:0] pat_lo_pipe;  // Pattern plane 0
  logic [15:0] pat_hi_pipe;  // Pattern plane 1
  logic [8:0]  attr_lo_pipe;
  logic [8:0]  attr_hi_pipe;
  logic [1:0]  attr_bits;    // Quadrant of the fetched attribute byte
  logic [7:0]  pat_lo;       // Low plane held until reload
  logic [1:0]  quad;

  // Pattern bytes hold the leftmost pixel in bit 7
  function automatic logic [7:0] bit_rev(input logic [7:0] b);
    logic [7:0] r;
    for (int k = 0; k < 8; k++) begin
      r[k] = b[7 - k];
    end
    return r;
  endfunction

  assign quad = {loopy.f.coarse_y[1], loopy.f.coarse_x[1]};

  // Data arrives one cycle after each even-cycle read
  always_ff @(posedge clk) begin
    case (cycle)
      3'd1: name_byte <= vram_din;
      3'd3: attr_bits <= vram_din[{quad, 1'b0} +: 2];
      3'd5: pat_lo    <= vram_din;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pat_lo_pipe  <= 16'd0;
      pat_hi_pipe  <= 16'd0;
      attr_lo_pipe <= 9'd0;
      attr_hi_pipe <= 9'd0;
    end else if (enable) begin
      pat_lo_pipe[14:0]  <= pat_lo_pipe[15:1];
      pat_hi_pipe[14:0]  <= pat_hi_pipe[15:1];
      attr_lo_pipe[7:0]  <= attr_lo_pipe[8:1];
      attr_hi_pipe[7:0]  <= attr_hi_pipe[8:1];
      if (cycle == 3'd7) begin             // High plane is on the bus now
        pat_lo_pipe[15:8] <= bit_rev(pat_lo);
        pat_hi_pipe[15:8] <= bit_rev(vram_din);
        attr_lo_pipe[8]   <= attr_bits[0];
        attr_hi_pipe[8]   <= attr_bits[1];
      end
    end
  end

  // Fine X picks how far into the pipe we look
  assign pixel = {attr_hi_pipe[fine_x], attr_lo_pipe[fine_x],
                  pat_hi_pipe[fine_x], pat_lo_pipe[fine_x]};

endmodule

/* ppu_palette.sv */
/*
 * 32-entry palette RAM with backdrop mirroring,
 * write masking and grayscale output
 */
`timescale 1ns/1ns

module ppu_palette (
  input  logic       clk,
  input  logic [4:0] addr,
  input  logic [5:0] din,
  input  logic       write,
  input  logic       grayscale,
  output logic [5:0] color
);

  // Power-up contents, a plain ramp over a dark backdrop
  logic [5:0] pal [32] = '{
    6'h0F, 6'h01, 6'h11, 6'h21,
    6'h0F, 6'h02, 6'h12, 6'h22,
    6'h0F, 6'h06, 6'h16, 6'h26,
    6'h0F, 6'h09, 6'h19, 6'h29,
    6'h0F, 6'h04, 6'h14, 6'h24,
    6'h0F, 6'h07, 6'h17, 6'h27,
    6'h0F, 6'h0A, 6'h1A, 6'h2A,
    6'h0F, 6'h0C, 6'h1C, 6'h3C
  };
  logic [4:0] idx;       // Index after backdrop folding
  logic [5:0] raw;
  logic       wr_ok;

  // Every colour 0 reads the shared backdrop
  assign idx = (addr[1:0] == 2'b00) ? 5'd0 : addr;
  assign raw = pal[idx];

  // Only 0 and 16 of the x0 slots are writable, both land on entry 0
  assign wr_ok = !(addr[3:2] != 2'b00 && addr[1:0] == 2'b00);

  always_ff @(posedge clk) begin
    if (write && wr_ok)
      pal[idx] <= din;
  end

  assign color = grayscale ? {raw[5:4], 4'b0000} : raw;  // Keep luma only

endmodule

/* ppu_top.sv */
/*
 * Picture processor top: control and mask registers, NMI and status,
 * VRAM address and strobes, read latch, left clipping and submodules
 */
`timescale 1ns/1ns
`include "ppu_defines.svh"

module ppu_top import ppu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic [2:0]  ain,
  input  logic [7:0]  din,
  input  logic        read,
  input  logic        write,
  output logic [7:0]  dout,
  output logic        nmi,
  output logic [13:0] vram_a,
  output logic        vram_r,
  output logic        vram_w,
  input  logic [7:0]  vram_din,
  output logic [7:0]  vram_dout,
  output logic [5:0]  color,
  output logic [8:0]  scanline,
  output logic [8:0]  cycle
);

  logic       bg_patt;         // Ctrl bit 4
  logic       nmi_enable;      // Ctrl bit 7
  logic       grayscale;       // Mask bit 0
  logic       bg_clip;         // Mask bit 1, show left column when set
  logic       playfield_en;    // Mask bit 3
  logic       nmi_flag;
  logic       vram_r_d;        // Read issued last cycle
  logic [7:0] vram_latch;
  logic       in_vblank, end_of_line, last_group;
  logic       entering_vblank, exiting_vblank, pre_render;
  logic       rendering;
  loopy_t     loopy;
  logic [2:0] fine_x;
  logic [7:0] name_byte;
  logic [3:0] bg_raw, bg_pixel;
  logic       show_bg, is_pal;
  logic [4:0] pal_addr;

  assign rendering = playfield_en && !in_vblank && scanline != `POST_RENDER_LINE;
  assign is_pal    = (loopy.addr[13:8] == `PAL_PAGE);

  ppu_timing u_timing (
    .clk, .reset, .rendering, .scanline, .cycle, .in_vblank, .end_of_line,
    .last_group, .entering_vblank, .exiting_vblank, .pre_render
  );

  ppu_scroll u_scroll (
    .clk, .reset, .rendering, .pre_render, .cycle, .ain, .din, .read, .write,
    .loopy, .fine_x
  );

  ppu_bg_painter u_bg (
    .clk, .reset, .enable(!last_group), .cycle(cycle[2:0]), .fine_x, .loopy,
    .vram_din, .name_byte, .pixel(bg_raw)
  );

  // Left 8 columns drop to backdrop unless clipping is off
  assign show_bg  = (bg_clip || cycle[7:3] != 5'd0) && playfield_en;
  assign bg_pixel = {bg_raw[3:2], show_bg ? bg_raw[1:0] : 2'b00};
  assign pal_addr = rendering ? {1'b0, bg_pixel} :
                    is_pal    ? loopy.addr[4:0] : 5'd0;

  ppu_palette u_palette (
    .clk, .addr(pal_addr), .din(din[5:0]),
    .write(write && ain == `REG_DATA && is_pal), .grayscale, .color
  );

  // Fetch phase picks name, attribute or pattern address
  always_comb begin
    if (!rendering)
      vram_a = loopy.addr[13:0];
    else if (cycle[2:1] == 2'd0)
      vram_a = {`NT_BASE, loopy.addr[11:0]};
    else if (cycle[2:1] == 2'd1)
      vram_a = {`NT_BASE, loopy.f.nt_y, loopy.f.nt_x, `ATTR_ROW,
                loopy.f.coarse_y[4:2], loopy.f.coarse_x[4:2]};
    else
      vram_a = {1'b0, bg_patt, name_byte, cycle[1], loopy.f.fine_y};  // Plane from cycle 1
  end

  assign vram_r = (read && ain == `REG_DATA) ||
                  (rendering && !cycle[0] && !end_of_line);
  assign vram_w = write && ain == `REG_DATA && !is_pal && !rendering;
  assign vram_dout = din;

  always_ff @(posedge clk) begin
    if (reset) begin
      bg_patt      <= 1'b0;
      nmi_enable   <= 1'b0;
      grayscale    <= 1'b0;
      bg_clip      <= 1'b0;
      playfield_en <= 1'b0;
      nmi_flag     <= 1'b0;
      vram_r_d     <= 1'b0;
    end else begin
      if (write && ain == `REG_CTRL) begin
        bg_patt    <= din[4];
        nmi_enable <= din[7];
      end
      if (write && ain == `REG_MASK) begin
        grayscale    <= din[0];
        bg_clip      <= din[1];
        playfield_en <= din[3];
      end
      if (entering_vblank)
        nmi_flag <= 1'b1;
      else if (exiting_vblank || (read && ain == `REG_STATUS))
        nmi_flag <= 1'b0;                 // Reading status acknowledges
      vram_r_d <= vram_r;
    end
  end

  // Bus data is valid the cycle after the strobe
  always_ff @(posedge clk) begin
    if (vram_r_d)
      vram_latch <= vram_din;
  end

  assign nmi = nmi_flag && nmi_enable;

  // Status has no sprite bits, data port reads palette directly
  always_comb begin
    if (ain == `REG_STATUS)
      dout = {nmi_flag, 7'b0000000};
    else if (is_pal)
      dout = {2'b00, color};
    else
      dout = vram_latch;
  end

  // Fetch reads and CPU writes never share the VRAM bus
  a_bus_excl: assert property (
    @(posedge clk) disable iff (reset) !(vram_r && vram_w)
  );

endmodule

/* tb_ppu.sv */
/*
 * Testbench for ppu_top: clock, reset, VRAM model, CPU bus tasks,
 * checking assertions, test sequence and final report
 */
`timescale 1ns/1ns
`include "ppu_defines.svh"

module tb_ppu;

  localparam int FRAME_CYCLES   = 341 * 262;
  localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 32000;  // Tests end early in frame 3

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic [2:0]  ain = 3'd0;
  logic [7:0]  din = 8'h00;
  logic        read = 1'b0;
  logic        write = 1'b0;
  logic [7:0]  dout;
  logic        nmi;
  logic [13:0] vram_a;
  logic        vram_r, vram_w;
  logic [7:0]  vram_din = 8'h00;
  logic [7:0]  vram_dout;
  logic [5:0]  color;
  logic [8:0]  scanline, cycle;
  logic [7:0]  mem [16384];          // 16 KB VRAM model

  // Expected state kept by the test sequence
  logic        pf_on = 1'b0;         // Playfield enable as last written
  logic        nmi_on = 1'b0;
  logic        vram_chk = 1'b0;
  logic        pal_chk = 1'b0;
  logic        pix_chk = 1'b0;
  logic        render_chk = 1'b0;
  logic        ctrl_bg = 1'b0;       // Control bit 4 as last written
  logic        rd_chk = 1'b0;
  logic [7:0]  rd_val = 8'h00;
  logic [7:0]  rd_mask = 8'h00;
  logic [13:0] exp_addr = 14'd0;
  logic [13:0] step = 14'd1;
  logic [5:0]  pix_color = 6'd0;
  logic [5:0]  backdrop = 6'd0;
  int          err_count = 0;
  int          test_err_start = 0;
  int          test_count = 0;
  int          fail_count = 0;
  int          cyc_count = 0;

  always #2 clk = ~clk;              // 4 ns period

  ppu_top dut0 (
    .clk, .reset, .ain, .din, .read, .write, .dout, .nmi, .vram_a, .vram_r,
    .vram_w, .vram_din, .vram_dout, .color, .scanline, .cycle
  );

  always @(posedge clk) begin
    if (vram_w)
      mem[vram_a] = vram_dout;
    if (vram_r)
      vram_din <= mem[vram_a];       // Valid the cycle after the strobe
  end

  always @(posedge clk) begin
    cyc_count <= cyc_count + 1;
    if (cyc_count == TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  // 260 jumps to line -1, line -1 rolls over to 0
  function automatic logic [8:0] next_line(input logic [8:0] l);
    if (l == `VBLANK_END_LINE)
      return `PRE_RENDER_LINE;
    if (l == `PRE_RENDER_LINE)
      return 9'd0;
    return l + 9'd1;
  endfunction

  task automatic report_error(input string msg);
    err_count++;
    $display("ERROR %0t: %s", $time, msg);
  endtask

  a_after_reset: assert property (@(posedge clk) $fell(reset) |->
    !nmi && !vram_r && !vram_w && scanline == 9'd0 && cycle == 9'd0)
    else report_error("outputs not idle after reset");
  a_cycle_step: assert property (@(posedge clk) disable iff (reset)
    (cycle != `LAST_CYCLE && cycle != 9'd339) |=> cycle == $past(cycle) + 9'd1)
    else report_error("cycle did not step by one");
  a_cycle_wrap: assert property (@(posedge clk) disable iff (reset)
    cycle == `LAST_CYCLE |=> cycle == 9'd0) else report_error("cycle did not wrap after 340");
  a_short_line: assert property (@(posedge clk) disable iff (reset)
    cycle == 9'd339 |=> cycle == `LAST_CYCLE || (cycle == 9'd0 && scanline == 9'd0 && pf_on))
    else report_error("short line outside rendering pre-render line");
  a_line_next: assert property (@(posedge clk) disable iff (reset)
    (cycle == 9'd0 && $past(cycle) != 9'd0) |-> scanline == next_line($past(scanline)))
    else report_error("wrong scanline sequence");
  a_nmi_rise: assert property (@(posedge clk) disable iff (reset)
    $rose(nmi) |-> scanline == 9'd241 && cycle == 9'd0) else report_error("nmi rose off line 241");
  a_nmi_vblank: assert property (@(posedge clk) disable iff (reset)
    (nmi_on && scanline == 9'd241 && cycle == 9'd0) |-> nmi) else report_error("nmi missing");
  a_nmi_ack: assert property (@(posedge clk) disable iff (reset)
    (read && ain == `REG_STATUS) |=> !nmi) else report_error("nmi high after status read");
  a_read_data: assert property (@(posedge clk) disable iff (reset)
    (read && rd_chk) |-> (dout & rd_mask) == rd_val) else report_error("wrong read data");
  a_vram_write: assert property (@(posedge clk) disable iff (reset)
    (write && ain == `REG_DATA && vram_chk) |->
    vram_w && vram_a == exp_addr && vram_dout == din) else report_error("bad VRAM write");
  a_vram_read: assert property (@(posedge clk) disable iff (reset)
    (read && ain == `REG_DATA && vram_chk) |-> vram_r && vram_a == exp_addr)
    else report_error("bad VRAM read address");
  a_pal_write: assert property (@(posedge clk) disable iff (reset)
    (write && ain == `REG_DATA && pal_chk) |-> !vram_w) else report_error("palette hit VRAM");
  a_pix_color: assert property (@(posedge clk) disable iff (reset)
    (pix_chk && scanline == 9'd1 && cycle >= 9'd16 && cycle <= 9'd239) |->
    color == pix_color) else report_error("wrong pixel color");
  a_pix_clip: assert property (@(posedge clk) disable iff (reset)
    (pix_chk && scanline == 9'd1 && cycle < 9'd8) |-> color == backdrop)
    else report_error("left column not clipped");
  a_fetch_nt: assert property (@(posedge clk) disable iff (reset)
    (render_chk && pf_on && scanline < `POST_RENDER_LINE && vram_r && cycle[2:1] == 2'd0)
    |-> vram_a[13:12] == `NT_BASE) else report_error("name fetch outside nametables");
  a_fetch_pat: assert property (@(posedge clk) disable iff (reset)
    (render_chk && pf_on && scanline < `POST_RENDER_LINE && vram_r && cycle[2] &&
     cycle < `VISIBLE_CYCLES) |-> vram_a[12] == ctrl_bg)
    else report_error("pattern fetch from wrong table");

  // Each access is one strobe cycle and one idle cycle
  task automatic cpu_write(input logic [2:0] a, input logic [7:0] d);
    ain   = a;
    din   = d;
    write = 1'b1;
    @(posedge clk);
    #1 write = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic cpu_read(input logic [2:0] a, input logic chk, input logic [7:0] val,
                          input logic [7:0] mask);
    ain     = a;
    rd_chk  = chk;
    rd_val  = val;
    rd_mask = mask;
    read    = 1'b1;
    @(posedge clk);
    #1 read = 1'b0;
    rd_chk = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic set_addr(input logic [13:0] a);
    cpu_write(`REG_ADDR, {2'b00, a[13:8]});
    cpu_write(`REG_ADDR, a[7:0]);
  endtask

  task automatic wait_line(input logic [8:0] l);
    while (scanline != l) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (err_count != test_err_start) begin
      fail_count++;
      $display("test %0d %s: failed", test_count, name);
    end else begin
      $display("test %0d %s: ok", test_count, name);
    end
    test_err_start = err_count;
  endtask

  initial begin
    void'($urandom(26));
    for (int i = 0; i < 16384; i++) begin
      mem[i] = 8'($urandom);
    end
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;

    // Free-running counters through a whole frame
    wait_line(`VBLANK_END_LINE);
    wait_line(`PRE_RENDER_LINE);
    wait_line(9'd0);
    end_test("timing");

    cpu_write(`REG_CTRL, 8'h80);
    nmi_on = 1'b1;
    wait_line(9'd241);
    cpu_read(`REG_STATUS, 1'b1, 8'h80, 8'hE0);  // Sprite bits read as zero
    nmi_on = 1'b0;
    cpu_write(`REG_CTRL, 8'h00);
    end_test("vblank nmi");

    vram_chk = 1'b1;
    set_addr(14'h2108);
    exp_addr = 14'h2108;
    cpu_write(`REG_DATA, 8'hA5);
    exp_addr = exp_addr + step;
    cpu_write(`REG_DATA, 8'h3C);
    exp_addr = exp_addr + step;
    cpu_write(`REG_CTRL, 8'h04);               // Step of 32
    step = 14'd32;
    cpu_write(`REG_DATA, 8'h5A);
    exp_addr = exp_addr + step;
    cpu_write(`REG_DATA, 8'hC3);
    exp_addr = exp_addr + step;
    set_addr(14'h2109);
    exp_addr = 14'h2109;
    cpu_read(`REG_DATA, 1'b0, 8'h00, 8'h00);   // Latch still stale
    exp_addr = exp_addr + step;
    cpu_read(`REG_DATA, 1'b1, 8'h3C, 8'hFF);
    vram_chk = 1'b0;
    cpu_write(`REG_CTRL, 8'h00);
    step = 14'd1;
    end_test("vram port");

    pal_chk = 1'b1;
    set_addr(14'h3F00);
    cpu_write(`REG_DATA, 8'h21);
    cpu_write(`REG_DATA, 8'hD5);               // Top two bits dropped
    set_addr(14'h3F01);
    cpu_read(`REG_DATA, 1'b1, 8'h15, 8'hFF);
    set_addr(14'h3F10);
    cpu_read(`REG_DATA, 1'b1, 8'h21, 8'hFF);   // Mirror of the backdrop
    cpu_write(`REG_MASK, 8'h01);
    set_addr(14'h3F01);
    cpu_read(`REG_DATA, 1'b1, 8'h10, 8'hFF);   // Grayscale keeps luma
    cpu_write(`REG_MASK, 8'h00);
    pal_chk = 1'b0;
    end_test("palette");

    for (int a = 0; a < 16'h2000; a++) begin
      mem[a] = 8'hFF;                          // Both pattern tables
    end
    for (int n = 0; n < 4; n++) begin
      for (int a = 16'h3C0; a < 16'h400; a++) begin
        mem[16'h2000 + n * 16'h400 + a] = 8'hFF;
      end
    end
    set_addr(14'h3F0F);
    cpu_write(`REG_DATA, 8'h2C);
    set_addr(14'h2000);
    pix_color = 6'h2C;
    backdrop  = 6'h21;
    cpu_write(`REG_MASK, 8'h08);               // Playfield on, left clip on
    pf_on = 1'b1;
    wait_line(`PRE_RENDER_LINE);
    wait_line(9'd0);
    render_chk = 1'b1;
    wait_line(9'd1);
    pix_chk = 1'b1;
    wait_line(9'd2);
    pix_chk = 1'b0;
    end_test("background pixels");

    render_chk = 1'b0;                         // Table switches mid-access
    cpu_write(`REG_CTRL, 8'h10);               // Second pattern table
    ctrl_bg = 1'b1;
    render_chk = 1'b1;
    wait_line(9'd5);
    render_chk = 1'b0;
    cpu_write(`REG_MASK, 8'h00);
    pf_on = 1'b0;
    end_test("fetch addresses");

    $display("tests %0d, failed %0d, errors %0d", test_count, fail_count, err_count);
    if (err_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

/* files.f */
+incdir+.
ppu_pkg.sv
ppu_timing.sv
ppu_scroll.sv
ppu_bg_painter.sv
ppu_palette.sv
ppu_top.sv
tb_ppu.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_ppu
FILELIST  := files.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST)) ppu_defines.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
